/* source/audio_pkg.sv */
`default_nettype none

package audio_pkg;

  localparam int sample_width     = 16;  // signed audio sample
  localparam int slot_width       = 24;  // mic data bits in one slot
  localparam int i2s_half_period  = 4;   // audio_clk cycles per i2s_clk half
  localparam int bits_per_frame   = 64;  // i2s_clk periods per lrcl period
  localparam int offset_avg_log2  = 4;   // 16 samples for the dc estimate
  localparam int delay_addr_width = 8;   // 256 entry delay memory

  // derived widths
  localparam int i2s_div_width   = $clog2(i2s_half_period);
  localparam int frame_cnt_width = $clog2(bits_per_frame);
  localparam int fraction_width  = slot_width - sample_width;

  // slot word split into the audio sample and the low bits we drop
  typedef struct packed {
    logic signed [sample_width-1:0] sample;
    logic [fraction_width-1:0]      fraction;
  } i2s_slot_fields_t;

  // the mic slot as shifted in, or as sample plus fraction
  typedef union packed {
    logic [slot_width-1:0] raw;
    i2s_slot_fields_t      fields;
  } i2s_slot_u;

  // forward half of a four-phase link, ack runs back on its own wire
  typedef struct packed {
    logic                           req;
    logic signed [sample_width-1:0] sample;
  } sample_link_t;

endpackage

`default_nettype wire

/* source/i2s_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_receiver (
  input wire                      audio_clk,
  input wire                      rst_in,
  input wire                      mic_data,
  output logic                    i2s_clk,
  output logic                    lrcl_clk,
  output audio_pkg::sample_link_t mic_link,
  input wire                      mic_ack
);
  import audio_pkg::*;

  logic [i2s_div_width-1:0]       div_count;
  logic                           div_end;    // last cycle of an i2s_clk half
  logic                           i2s_rise;
  logic [frame_cnt_width-1:0]     bit_count;  // i2s_clk periods into the frame
  logic                           slot_bit;
  i2s_slot_u                      slot;
  logic                           word_done;
  logic                           link_req;
  logic signed [sample_width-1:0] link_sample;

  assign div_end  = (div_count == i2s_div_width'(i2s_half_period - 1));
  assign i2s_rise = div_end && !i2s_clk;

  // lrcl low for the left half of the frame
  assign lrcl_clk = bit_count[frame_cnt_width-1];

  // data starts one bit clock after lrcl falls, MSB first
  assign slot_bit = (bit_count != '0) && (bit_count <= frame_cnt_width'(slot_width));

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      div_count <= '0;
      i2s_clk   <= 1'b0;
      bit_count <= '0;
    end else begin
      div_count <= div_end ? '0 : div_count + 1'b1;
      if (div_end) begin
        i2s_clk <= !i2s_clk;
      end
      if (div_end && i2s_clk) begin
        bit_count <= bit_count + 1'b1;  // advance on the falling edge, wraps per frame
      end
    end
  end

  // mic drives data after the fall, so take it on the rise
  always_ff @(posedge audio_clk) begin
    if (i2s_rise && slot_bit) begin
      slot.raw <= {slot.raw[slot_width-2:0], mic_data};
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      word_done <= 1'b0;
      link_req  <= 1'b0;
    end else begin
      word_done <= i2s_rise && (bit_count == frame_cnt_width'(slot_width));
      if (word_done) begin
        link_req <= 1'b1;
      end else if (link_req && mic_ack) begin
        link_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (word_done) begin
      link_sample <= slot.fields.sample;  // fraction bits dropped here
    end
  end

  assign mic_link = '{req: link_req, sample: link_sample};

  // the chain has a whole frame to drain, so the last handshake is closed by now
  assert property (@(posedge audio_clk) disable iff (rst_in)
    word_done |-> (!link_req && !mic_ack))
    else $error("i2s_receiver: word completed while previous handshake open");

endmodule

`default_nettype wire

/* source/dc_offset_remover.sv */
`timescale 1ns/100ps
`default_nettype none

module dc_offset_remover (
  input wire                      audio_clk,
  input wire                      rst_in,
  input wire                      offset_trigger,
  input wire audio_pkg::sample_link_t in_link,
  output logic                    in_ack,
  output audio_pkg::sample_link_t out_link,
  input wire                      out_ack
);
  import audio_pkg::*;

  localparam int acc_width = sample_width + offset_avg_log2;

  logic signed [sample_width-1:0] in_sample;   // captured input
  logic                           have_sample; // captured, not yet forwarded
  logic                           out_req;
  logic signed [sample_width-1:0] out_sample;
  logic                           busy;
  logic                           take;

  logic                           learning;
  logic [offset_avg_log2-1:0]     learn_count;
  logic signed [acc_width-1:0]    acc;
  logic signed [acc_width-1:0]    acc_next;
  logic signed [acc_width-1:0]    acc_mean;
  logic                           offset_valid;
  logic signed [sample_width-1:0] offset;
  logic [sample_width:0]          diff;        // one guard bit for saturation
  logic signed [sample_width-1:0] corrected;

  // no new capture until the output handshake has fully closed
  assign busy = have_sample || out_req || out_ack;
  assign take = in_link.req && !in_ack && !busy;

  assign acc_next = acc + acc_width'(in_sample);
  assign acc_mean = acc_next >>> offset_avg_log2;

  always_comb begin
    diff = {in_sample[sample_width-1], in_sample} - {offset[sample_width-1], offset};
    if (!offset_valid) begin
      corrected = in_sample;  // pass through until learned
    end else if (diff[sample_width] != diff[sample_width-1]) begin
      // overflow, clamp to the rail on the side of the sign
      corrected = diff[sample_width] ? {1'b1, {(sample_width-1){1'b0}}}
                                     : {1'b0, {(sample_width-1){1'b1}}};
    end else begin
      corrected = diff[sample_width-1:0];
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      in_ack      <= 1'b0;
      have_sample <= 1'b0;
      out_req     <= 1'b0;
    end else begin
      if (take) begin
        in_ack <= 1'b1;
      end else if (!in_link.req) begin
        in_ack <= 1'b0;
      end
      have_sample <= take;
      if (have_sample) begin
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (take) begin
      in_sample <= in_link.sample;
    end
    if (have_sample) begin
      out_sample <= corrected;
    end
  end

  // trigger (re)starts learning, old offset stays in use meanwhile
  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      learning     <= 1'b0;
      learn_count  <= '0;
      acc          <= '0;
      offset_valid <= 1'b0;
    end else if (offset_trigger) begin
      learning    <= 1'b1;
      learn_count <= '0;
      acc         <= '0;
    end else if (learning && have_sample) begin
      acc         <= acc_next;
      learn_count <= learn_count + 1'b1;
      if (&learn_count) begin
        learning     <= 1'b0;
        offset_valid <= 1'b1;
        offset       <= acc_mean[sample_width-1:0];
      end
    end
  end

  assign out_link = '{req: out_req, sample: out_sample};

  assert property (@(posedge audio_clk) disable iff (rst_in)
    (out_link.req && $past(out_link.req)) |-> $stable(out_link.sample))
    else $error("dc_offset_remover: sample changed while req high");

endmodule

`default_nettype wire

/* source/delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

module delay_line (
  input wire                          audio_clk,
  input wire                          rst_in,
  input wire [audio_pkg::delay_addr_width-1:0] delay_length,
  input wire audio_pkg::sample_link_t in_link,
  output logic                        in_ack,
  output audio_pkg::sample_link_t     out_link,
  input wire                          out_ack
);
  import audio_pkg::*;

  localparam int depth = 1 << delay_addr_width;

  logic signed [sample_width-1:0] mem [0:depth-1];

  logic [delay_addr_width-1:0]    wr_ptr;
  logic [delay_addr_width-1:0]    rd_addr;
  logic [delay_addr_width:0]      fill_count;   // saturates at depth
  logic                           take;
  logic                           busy;
  logic                           read_pending; // write done, read next
  logic                           out_pending;  // read done, offer next
  logic signed [sample_width-1:0] rd_data;
  logic                           rd_valid;     // enough history for this delay
  logic                           out_req;
  logic signed [sample_width-1:0] out_sample;

  assign busy = read_pending || out_pending || out_req || out_ack;
  assign take = in_link.req && !in_ack && !busy;

  // wr_ptr has already moved past the sample just written
  assign rd_addr = wr_ptr - delay_length - 1'b1;

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      in_ack       <= 1'b0;
      wr_ptr       <= '0;
      fill_count   <= '0;
      read_pending <= 1'b0;
      out_pending  <= 1'b0;
      out_req      <= 1'b0;
    end else begin
      if (take) begin
        in_ack <= 1'b1;
      end else if (!in_link.req) begin
        in_ack <= 1'b0;
      end

      if (take) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (!fill_count[delay_addr_width]) begin
          fill_count <= fill_count + 1'b1;
        end
      end

      read_pending <= take;
      out_pending  <= read_pending;

      if (out_pending) begin
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

  // memory is never cleared, unwritten slots are masked by rd_valid
  always_ff @(posedge audio_clk) begin
    if (take) begin
      mem[wr_ptr] <= in_link.sample;
    end
    if (read_pending) begin
      rd_data  <= mem[rd_addr];
      rd_valid <= fill_count > {1'b0, delay_length};
    end
    if (out_pending) begin
      out_sample <= rd_valid ? rd_data : '0;
    end
  end

  assign out_link = '{req: out_req, sample: out_sample};

endmodule

`default_nettype wire

/* source/pdm_modulator.sv */
`timescale 1ns/100ps
`default_nettype none

module pdm_modulator (
  input wire                                     audio_clk,
  input wire                                     rst_in,
  input wire audio_pkg::sample_link_t            in_link,
  output logic                                   in_ack,
  output logic                                   pdm_out,
  output logic signed [audio_pkg::sample_width-1:0] played_sample,
  output logic                                   played_strobe
);
  import audio_pkg::*;

  logic signed [sample_width-1:0] level;   // held until the next sample
  logic [sample_width-1:0]        acc;
  logic [sample_width:0]          acc_sum;

  // flipping the sign bit maps -32768..32767 onto 0..65535
  assign acc_sum = {1'b0, acc} + {1'b0, ~level[sample_width-1], level[sample_width-2:0]};

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      in_ack        <= 1'b0;
      played_strobe <= 1'b0;
      level         <= '0;
      acc           <= '0;
      pdm_out       <= 1'b0;
    end else begin
      played_strobe <= 1'b0;
      if (in_link.req && !in_ack) begin
        in_ack        <= 1'b1;
        level         <= in_link.sample;
        played_strobe <= 1'b1;  // end of the sample's trip
      end else if (!in_link.req) begin
        in_ack <= 1'b0;
      end
      acc     <= acc_sum[sample_width-1:0];
      pdm_out <= acc_sum[sample_width];  // carry out is the bit stream
    end
  end

  assign played_sample = level;

endmodule

`default_nettype wire

/* source/audio_top.sv */
`timescale 1ns/100ps
`default_nettype none

module audio_top (
  input wire                                        audio_clk,
  input wire                                        rst_in,
  input wire                                        mic_data,
  input wire                                        offset_trigger,
  input wire [audio_pkg::delay_addr_width-1:0]      delay_length,
  output logic                                      i2s_clk,
  output logic                                      lrcl_clk,
  output logic                                      pdm_out,
  output logic signed [audio_pkg::sample_width-1:0] played_sample,
  output logic                                      played_strobe
);
  import audio_pkg::*;

  sample_link_t mic_link;    // receiver to offset remover
  sample_link_t clean_link;  // offset remover to delay line
  sample_link_t play_link;   // delay line to modulator
  logic         mic_ack;
  logic         clean_ack;
  logic         play_ack;

  i2s_receiver receiver0 (
    .audio_clk (audio_clk),
    .rst_in    (rst_in),
    .mic_data  (mic_data),
    .i2s_clk   (i2s_clk),
    .lrcl_clk  (lrcl_clk),
    .mic_link  (mic_link),
    .mic_ack   (mic_ack)
  );

  dc_offset_remover offset0 (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .offset_trigger (offset_trigger),
    .in_link        (mic_link),
    .in_ack         (mic_ack),
    .out_link       (clean_link),
    .out_ack        (clean_ack)
  );

  delay_line delay0 (
    .audio_clk    (audio_clk),
    .rst_in       (rst_in),
    .delay_length (delay_length),
    .in_link      (clean_link),
    .in_ack       (clean_ack),
    .out_link     (play_link),
    .out_ack      (play_ack)
  );

  pdm_modulator pdm0 (
    .audio_clk     (audio_clk),
    .rst_in        (rst_in),
    .in_link       (play_link),
    .in_ack        (play_ack),
    .pdm_out       (pdm_out),
    .played_sample (played_sample),
    .played_strobe (played_strobe)
  );

endmodule

`default_nettype wire

/* tests/audio_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module audio_top_tb;
  import audio_pkg::*;

  localparam int strobe_timeout = 600;  // cycles, one frame plus margin
  localparam int max_words      = 256;
  localparam int pdm_window     = 4096;

  logic                           audio_clk = 1'b0;
  logic                           rst_in;
  logic                           mic_data = 1'b0;
  logic                           offset_trigger;
  logic [delay_addr_width-1:0]    delay_length;
  logic                           i2s_clk;
  logic                           lrcl_clk;
  logic                           pdm_out;
  logic signed [sample_width-1:0] played_sample;
  logic                           played_strobe;

  i2s_slot_u   words [0:max_words-1];  // slot words queued for the mic
  int          word_total;
  int          word_index;             // next word the mic sends
  int          fall_count;             // bit clock falls into the left slot
  i2s_slot_u   mic_word = '0;
  logic [31:0] lfsr;
  int          checks;
  int          errors;

  audio_top dut0 (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .mic_data       (mic_data),
    .offset_trigger (offset_trigger),
    .delay_length   (delay_length),
    .i2s_clk        (i2s_clk),
    .lrcl_clk       (lrcl_clk),
    .pdm_out        (pdm_out),
    .played_sample  (played_sample),
    .played_strobe  (played_strobe)
  );

  always #4 audio_clk = ~audio_clk;

  // mic model, left slot only, data moves just after the bit clock falls
  always begin
    @(negedge i2s_clk or posedge rst_in);
    #1;
    if (rst_in) begin
      fall_count = 1;  // receiver restarts as if lrcl just fell
      word_index = 0;
      mic_data   = 1'b0;
    end else if (lrcl_clk) begin
      fall_count = 0;
      mic_data   = 1'b0;
    end else begin
      fall_count = fall_count + 1;
      if (fall_count == 2 && word_index < word_total) begin
        mic_word   = words[word_index];
        word_index = word_index + 1;
      end
      // otherwise the last word repeats
      if (fall_count >= 2 && fall_count <= slot_width + 1) begin
        mic_data = mic_word.raw[slot_width + 1 - fall_count];  // msb first
      end else begin
        mic_data = 1'b0;
      end
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic random_word(output i2s_slot_u w);
    logic [31:0] bits;
    random_bits(slot_width, bits);
    w.raw = bits[slot_width-1:0];
  endtask

  // fixed sample, random fraction below it
  task automatic word_with_sample(input int s, output i2s_slot_u w);
    logic [31:0] bits;
    random_bits(fraction_width, bits);
    w.fields.sample   = 16'(s);
    w.fields.fraction = bits[fraction_width-1:0];
  endtask

  function automatic int word_sample(input i2s_slot_u w);
    return int'($signed(w.raw[slot_width-1:fraction_width]));  // upper 16 bits
  endfunction

  function automatic int saturate(input int v);
    if (v > 32767) begin
      return 32767;
    end
    if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  task automatic push_word(input i2s_slot_u w);
    if (word_total < max_words) begin
      words[word_total] = w;
      word_total = word_total + 1;
    end
  endtask

  task automatic next_cycle();
    @(posedge audio_clk);
    #1;
  endtask

  task automatic check_value(input string what, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
      errors++;
      $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic check_idle_outputs();
    checks++;
    assert (pdm_out === 1'b0 && played_strobe === 1'b0 && i2s_clk === 1'b0
            && lrcl_clk === 1'b0 && played_sample === '0) else begin
      errors++;
      $display("Mismatch at %0d ns: outputs not idle, pdm %b strobe %b i2s %b lrcl %b sample %0d",
               $time, pdm_out, played_strobe, i2s_clk, lrcl_clk, played_sample);
    end
  endtask

  task automatic reset_dut(input int delay, input bit check_outputs);
    rst_in         = 1'b1;
    offset_trigger = 1'b0;
    delay_length   = delay_addr_width'(delay);
    word_total     = 0;
    repeat (10) begin
      next_cycle();
      if (check_outputs) check_idle_outputs();
    end
    rst_in = 1'b0;
    next_cycle();
    if (check_outputs) check_idle_outputs();  // first cycle out of reset
  endtask

  task automatic wait_strobe(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < strobe_timeout && !seen; n++) begin
      next_cycle();
      seen = played_strobe;
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("Timeout at %0d ns: no played_strobe within %0d cycles", $time, strobe_timeout);
    end
  endtask

  task automatic test_reset_state();
    reset_dut(0, 1'b1);
  endtask

  task automatic test_passthrough();
    i2s_slot_u w;
    bit        seen;
    int        k;
    reset_dut(0, 1'b0);
    for (k = 0; k < 8; k++) begin
      random_word(w);
      push_word(w);
    end
    for (k = 0; k < 8; k++) begin
      wait_strobe(seen);
      if (seen) check_value("passthrough sample", int'(played_sample), word_sample(words[k]));
    end
  endtask

  // strobes before first_checked are awaited but not compared
  task automatic test_delay(input int delay, input int total, input int first_checked);
    i2s_slot_u w;
    bit        seen;
    int        k;
    int        expected;
    reset_dut(delay, 1'b0);
    for (k = 0; k < total; k++) begin
      random_word(w);
      push_word(w);
    end
    for (k = 0; k < total; k++) begin
      wait_strobe(seen);
      if (k < delay) begin
        expected = 0;  // not enough history yet
      end else begin
        expected = word_sample(words[k - delay]);
      end
      if (seen && k >= first_checked) begin
        check_value($sformatf("delayed sample %0d", k), int'(played_sample), expected);
      end
    end
  endtask

  task automatic test_offset(input int c, input int x0, input int x1, input int x2);
    i2s_slot_u w;
    int        xs [0:7];
    bit        seen;
    int        k;
    reset_dut(0, 1'b0);
    offset_trigger = 1'b1;
    next_cycle();
    offset_trigger = 1'b0;
    for (k = 0; k < 16; k++) begin
      word_with_sample(c, w);
      push_word(w);
    end
    xs[0] = x0;
    xs[1] = x1;
    xs[2] = x2;
    for (k = 0; k < 3; k++) begin
      word_with_sample(xs[k], w);
      push_word(w);
    end
    for (k = 3; k < 8; k++) begin
      random_word(w);
      xs[k] = word_sample(w);
      push_word(w);
    end
    // offset is not valid until the 16th sample has gone through
    for (k = 0; k < 16; k++) begin
      wait_strobe(seen);
      if (seen) check_value("sample while learning", int'(played_sample), c);
    end
    for (k = 0; k < 8; k++) begin
      wait_strobe(seen);
      if (seen) check_value("corrected sample", int'(played_sample), saturate(xs[k] - c));
    end
  endtask

  task automatic test_pdm_density(input int s);
    i2s_slot_u w;
    bit        seen;
    int        ones;
    int        expected;
    int        n;
    reset_dut(0, 1'b0);
    word_with_sample(s, w);
    push_word(w);  // repeats every frame, so the level holds
    wait_strobe(seen);
    if (seen) check_value("pdm level", int'(played_sample), s);
    next_cycle();
    next_cycle();
    ones = 0;
    for (n = 0; n < pdm_window; n++) begin
      next_cycle();
      if (pdm_out) ones++;
    end
    expected = (s + 32768) * pdm_window / 65536;
    checks++;
    assert (ones >= expected - 2 && ones <= expected + 2) else begin
      errors++;
      $display("Mismatch at %0d ns: %0d ones for level %0d, expected %0d within 2",
               $time, ones, s, expected);
    end
  endtask

  initial begin
    lfsr           = 32'hb3e1_eff9;
    checks         = 0;
    errors         = 0;
    rst_in         = 1'b1;
    offset_trigger = 1'b0;
    delay_length   = '0;
    word_total     = 0;

    test_reset_state();
    test_passthrough();
    test_delay(5, 12, 0);
    test_delay(200, 206, 196);
    test_offset(12000, -30000, -32768, 20767);   // clamps low
    test_offset(-12000, 30000, 32767, -32768);   // clamps high
    test_pdm_density(-32768);
    test_pdm_density(-16384);
    test_pdm_density(0);
    test_pdm_density(12345);
    test_pdm_density(32767);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/audio_pkg.sv
source/i2s_receiver.sv
source/dc_offset_remover.sv
source/delay_line.sv
source/pdm_modulator.sv
source/audio_top.sv
tests/audio_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the audio_top testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module audio_top_tb \
  -f compile.f -o audio_top_sim || exit 1
sim_out=$(./obj_dir/audio_top_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "No errors" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
